// File: rtl/graph_fetch_pkg.sv
package graph_fetch_pkg;

	////////////////////
	// Widths
	////////////////////

	// Vertex identifier
	localparam int VERTEX_ID_W = 16;

	// Vertex property word, also the Wishbone data width
	localparam int DATA_W = 32;

	// Wishbone byte address and data base address
	localparam int ADDR_W = 32;

	////////////////////
	// Vertex data layout
	////////////////////

	// Bytes per vertex property word
	localparam int DATA_SIZE_READ = 4;

	////////////////////
	// Buffering
	////////////////////

	localparam int JOB_BUFFER_DEPTH = 16;

	// Free entries at or below which a buffer reports almost full
	localparam int ALMOST_FULL_MARGIN = 4;

	// Wishbone master FSM encoding
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_GRANT = 2'd1;
	localparam logic [1:0] ST_CYCLE = 2'd2;

endpackage

// File: rtl/sync_fifo.sv
module sync_fifo #(
	parameter int WIDTH = graph_fetch_pkg::DATA_W,
	parameter int DEPTH = graph_fetch_pkg::JOB_BUFFER_DEPTH
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);
	import graph_fetch_pkg::*;

	logic [WIDTH-1:0]             mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]     wr_ptr;
	logic [$clog2(DEPTH)-1:0]     rd_ptr;
	logic [$clog2(DEPTH+1)-1:0]   count;
	logic                         do_push;
	logic                         do_pop;

	// Status flags straight from the fill count
	assign full        = (int'(count) == DEPTH);
	assign almost_full = ((DEPTH - int'(count)) <= ALMOST_FULL_MARGIN);
	assign empty       = (count == '0);

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_pop;
			if (do_push) begin
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

	////////////////////
	// Checks
	////////////////////

	a_no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		push |-> !full);

	a_no_pop_when_empty: assert property (@(posedge clock) disable iff (!rstn)
		pop |-> !empty);

endmodule

// File: rtl/edge_data_read_command_control.sv
module edge_data_read_command_control (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    enabled,
	input  logic [graph_fetch_pkg::ADDR_W-1:0]      data_base,
	input  logic                                    edge_job_valid,
	input  logic [graph_fetch_pkg::VERTEX_ID_W-1:0] edge_job_src,
	input  logic [graph_fetch_pkg::VERTEX_ID_W-1:0] edge_job_dest,
	input  logic                                    edge_data_request,
	input  logic                                    read_command_bus_grant,
	input  logic                                    read_response_valid,
	input  logic [graph_fetch_pkg::VERTEX_ID_W-1:0] read_response_dest,
	input  logic [graph_fetch_pkg::DATA_W-1:0]      read_response_data,
	output logic                                    edge_request,
	output logic                                    edge_data_valid,
	output logic [graph_fetch_pkg::VERTEX_ID_W-1:0] edge_data_dest,
	output logic [graph_fetch_pkg::DATA_W-1:0]      edge_data_value,
	output logic                                    edge_data_empty,
	output logic                                    read_command_bus_request,
	output logic                                    read_command_valid,
	output logic [graph_fetch_pkg::ADDR_W-1:0]      read_command_address,
	output logic [graph_fetch_pkg::VERTEX_ID_W-1:0] read_command_dest
);
	import graph_fetch_pkg::*;

	logic                      enabled_latched;
	logic [ADDR_W-1:0]         data_base_latched;

	// Input latch stage
	logic                      edge_job_valid_latched;
	logic [VERTEX_ID_W-1:0]    edge_job_src_latched;
	logic [VERTEX_ID_W-1:0]    edge_job_dest_latched;
	logic                      edge_data_request_latched;
	logic                      read_command_bus_grant_latched;
	logic                      read_response_valid_latched;
	logic [VERTEX_ID_W-1:0]    read_response_dest_latched;
	logic [DATA_W-1:0]         read_response_data_latched;

	// Edge job buffer, src in the upper half
	logic [2*VERTEX_ID_W-1:0]  edge_job_out;
	logic                      edge_job_out_valid;
	logic                      edge_job_full;
	logic                      edge_job_almost_full;
	logic                      edge_job_empty;
	logic                      edge_job_pop;

	// Command build stage and read command buffer
	logic                      command_valid_latched;
	logic [ADDR_W-1:0]         command_address_latched;
	logic [VERTEX_ID_W-1:0]    command_dest_latched;
	logic [ADDR_W+VERTEX_ID_W-1:0] read_command_out;
	logic                      read_command_out_valid;
	logic                      read_command_full;
	logic                      read_command_almost_full;
	logic                      read_command_empty;
	logic                      read_command_pop;

	// Edge data buffer, dest in the upper bits
	logic [VERTEX_ID_W+DATA_W-1:0] edge_data_out;
	logic                      edge_data_out_valid;
	logic                      edge_data_full;
	logic                      edge_data_almost_full;
	logic                      edge_data_fifo_empty;
	logic                      edge_data_pop;

	////////////////////
	// Enable and setup
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_latched <= 1'b0;
		end else begin
			enabled_latched <= enabled;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled_latched) begin
			data_base_latched <= data_base;
		end
	end

	////////////////////
	// Input latches
	////////////////////

	// Job and response latches stay open so work already in flight is kept
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_job_valid_latched         <= 1'b0;
			edge_data_request_latched      <= 1'b0;
			read_command_bus_grant_latched <= 1'b0;
			read_response_valid_latched    <= 1'b0;
		end else begin
			edge_job_valid_latched         <= edge_job_valid;
			edge_data_request_latched      <= enabled_latched && edge_data_request;
			read_command_bus_grant_latched <= read_command_bus_grant;
			read_response_valid_latched    <= read_response_valid;
		end
	end

	always_ff @(posedge clock) begin
		edge_job_src_latched       <= edge_job_src;
		edge_job_dest_latched      <= edge_job_dest;
		read_response_dest_latched <= read_response_dest;
		read_response_data_latched <= read_response_data;
	end

	////////////////////
	// Edge job buffer
	////////////////////

	assign edge_job_pop = enabled_latched && !edge_job_empty && !read_command_almost_full
		&& !read_command_full;

	sync_fifo #(
		.WIDTH(2 * VERTEX_ID_W),
		.DEPTH(JOB_BUFFER_DEPTH)
	) edge_job_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (edge_job_valid_latched),
		.data_in    ({edge_job_src_latched, edge_job_dest_latched}),
		.pop        (edge_job_pop),
		.data_out   (edge_job_out),
		.valid      (edge_job_out_valid),
		.full       (edge_job_full),
		.almost_full(edge_job_almost_full),
		.empty      (edge_job_empty)
	);

	// Vertex word address is base plus dest times the stride
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_valid_latched <= 1'b0;
		end else begin
			command_valid_latched <= edge_job_out_valid;
		end
	end

	always_ff @(posedge clock) begin
		command_address_latched <= data_base_latched
			+ ADDR_W'(edge_job_out[VERTEX_ID_W-1:0]) * ADDR_W'(DATA_SIZE_READ);
		command_dest_latched    <= edge_job_out[VERTEX_ID_W-1:0];
	end

	////////////////////
	// Read command buffer
	////////////////////

	// One pop per latched grant
	assign read_command_pop = read_command_bus_grant_latched && !read_command_empty;

	sync_fifo #(
		.WIDTH(ADDR_W + VERTEX_ID_W),
		.DEPTH(JOB_BUFFER_DEPTH)
	) read_command_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (command_valid_latched),
		.data_in    ({command_address_latched, command_dest_latched}),
		.pop        (read_command_pop),
		.data_out   (read_command_out),
		.valid      (read_command_out_valid),
		.full       (read_command_full),
		.almost_full(read_command_almost_full),
		.empty      (read_command_empty)
	);

	////////////////////
	// Edge data buffer
	////////////////////

	// Extra requests against an empty buffer are dropped
	assign edge_data_pop = edge_data_request_latched && !edge_data_fifo_empty;

	sync_fifo #(
		.WIDTH(VERTEX_ID_W + DATA_W),
		.DEPTH(JOB_BUFFER_DEPTH)
	) edge_data_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (read_response_valid_latched),
		.data_in    ({read_response_dest_latched, read_response_data_latched}),
		.pop        (edge_data_pop),
		.data_out   (edge_data_out),
		.valid      (edge_data_out_valid),
		.full       (edge_data_full),
		.almost_full(edge_data_almost_full),
		.empty      (edge_data_fifo_empty)
	);

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_request             <= 1'b0;
			edge_data_valid          <= 1'b0;
			edge_data_empty          <= 1'b1;
			read_command_bus_request <= 1'b0;
			read_command_valid       <= 1'b0;
		end else begin
			edge_request             <= enabled_latched && !edge_job_almost_full
				&& !edge_job_full;
			edge_data_valid          <= edge_data_out_valid;
			edge_data_empty          <= edge_data_fifo_empty;
			read_command_bus_request <= enabled_latched && !read_command_empty
				&& !edge_data_almost_full && !edge_data_full;
			read_command_valid       <= read_command_out_valid;
		end
	end

	always_ff @(posedge clock) begin
		edge_data_dest       <= edge_data_out[DATA_W +: VERTEX_ID_W];
		edge_data_value      <= edge_data_out[DATA_W-1:0];
		read_command_address <= read_command_out[VERTEX_ID_W +: ADDR_W];
		read_command_dest    <= read_command_out[VERTEX_ID_W-1:0];
	end

	// Master must only grant a request it saw
	a_grant_follows_request: assert property (@(posedge clock) disable iff (!rstn)
		read_command_bus_grant |-> $past(read_command_bus_request));

endmodule

// File: rtl/vertex_read_wb_master.sv
module vertex_read_wb_master (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    read_command_bus_request,
	input  logic                                    read_command_valid,
	input  logic [graph_fetch_pkg::ADDR_W-1:0]      read_command_address,
	input  logic [graph_fetch_pkg::VERTEX_ID_W-1:0] read_command_dest,
	input  logic [graph_fetch_pkg::DATA_W-1:0]      wb_dat_i,
	input  logic                                    wb_ack,
	output logic                                    read_command_bus_grant,
	output logic                                    read_response_valid,
	output logic [graph_fetch_pkg::VERTEX_ID_W-1:0] read_response_dest,
	output logic [graph_fetch_pkg::DATA_W-1:0]      read_response_data,
	output logic                                    wb_cyc,
	output logic                                    wb_stb,
	output logic [graph_fetch_pkg::ADDR_W-1:0]      wb_adr
);
	import graph_fetch_pkg::*;

	logic [1:0] state;
	logic       command_accept;
	logic       cycle_done;

	assign command_accept = (state == ST_GRANT) && read_command_valid;
	assign cycle_done     = (state == ST_CYCLE) && wb_ack;

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state                  <= ST_IDLE;
			read_command_bus_grant <= 1'b0;
			read_response_valid    <= 1'b0;
			wb_cyc                 <= 1'b0;
			wb_stb                 <= 1'b0;
		end else begin
			// Grant and response are single cycle pulses
			read_command_bus_grant <= 1'b0;
			read_response_valid    <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (read_command_bus_request) begin
						read_command_bus_grant <= 1'b1;
						state                  <= ST_GRANT;
					end
				end
				ST_GRANT: begin
					// Wait for the popped command
					if (command_accept) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						state  <= ST_CYCLE;
					end
				end
				ST_CYCLE: begin
					if (cycle_done) begin
						wb_cyc              <= 1'b0;
						wb_stb              <= 1'b0;
						read_response_valid <= 1'b1;
						state               <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address and tag held from accept until the ack
	always_ff @(posedge clock) begin
		if (command_accept) begin
			wb_adr             <= read_command_address;
			read_response_dest <= read_command_dest;
		end
		if (cycle_done) begin
			read_response_data <= wb_dat_i;
		end
	end

	////////////////////
	// Bus checks
	////////////////////

	a_stb_inside_cyc: assert property (@(posedge clock) disable iff (!rstn)
		wb_stb |-> wb_cyc);

	a_adr_stable: assert property (@(posedge clock) disable iff (!rstn)
		wb_stb && !wb_ack |=> $stable(wb_adr));

endmodule

// File: rtl/edge_data_fetch_top.sv
module edge_data_fetch_top (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    enabled,
	input  logic [graph_fetch_pkg::ADDR_W-1:0]      data_base,
	input  logic                                    edge_job_valid,
	input  logic [graph_fetch_pkg::VERTEX_ID_W-1:0] edge_job_src,
	input  logic [graph_fetch_pkg::VERTEX_ID_W-1:0] edge_job_dest,
	output logic                                    edge_request,
	input  logic                                    edge_data_request,
	output logic                                    edge_data_valid,
	output logic [graph_fetch_pkg::VERTEX_ID_W-1:0] edge_data_dest,
	output logic [graph_fetch_pkg::DATA_W-1:0]      edge_data_value,
	output logic                                    edge_data_empty,
	output logic                                    wb_cyc,
	output logic                                    wb_stb,
	output logic [graph_fetch_pkg::ADDR_W-1:0]      wb_adr,
	input  logic [graph_fetch_pkg::DATA_W-1:0]      wb_dat_i,
	input  logic                                    wb_ack
);
	import graph_fetch_pkg::*;

	// Command path between control and master
	logic                   read_command_bus_request;
	logic                   read_command_bus_grant;
	logic                   read_command_valid;
	logic [ADDR_W-1:0]      read_command_address;
	logic [VERTEX_ID_W-1:0] read_command_dest;

	// Response path back into the edge data buffer
	logic                   read_response_valid;
	logic [VERTEX_ID_W-1:0] read_response_dest;
	logic [DATA_W-1:0]      read_response_data;

	edge_data_read_command_control u_control (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled                 (enabled),
		.data_base               (data_base),
		.edge_job_valid          (edge_job_valid),
		.edge_job_src            (edge_job_src),
		.edge_job_dest           (edge_job_dest),
		.edge_data_request       (edge_data_request),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_response_valid     (read_response_valid),
		.read_response_dest      (read_response_dest),
		.read_response_data      (read_response_data),
		.edge_request            (edge_request),
		.edge_data_valid         (edge_data_valid),
		.edge_data_dest          (edge_data_dest),
		.edge_data_value         (edge_data_value),
		.edge_data_empty         (edge_data_empty),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid),
		.read_command_address    (read_command_address),
		.read_command_dest       (read_command_dest)
	);

	vertex_read_wb_master u_wb_master (
		.clock                   (clock),
		.rstn                    (rstn),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid),
		.read_command_address    (read_command_address),
		.read_command_dest       (read_command_dest),
		.wb_dat_i                (wb_dat_i),
		.wb_ack                  (wb_ack),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_response_valid     (read_response_valid),
		.read_response_dest      (read_response_dest),
		.read_response_data      (read_response_data),
		.wb_cyc                  (wb_cyc),
		.wb_stb                  (wb_stb),
		.wb_adr                  (wb_adr)
	);

endmodule

// File: tests/wb_vertex_memory_model.sv
module wb_vertex_memory_model #(
	parameter int SEED     = 3,
	parameter int MAX_WAIT = 3
) (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               wb_cyc,
	input  logic                               wb_stb,
	input  logic [graph_fetch_pkg::ADDR_W-1:0] wb_adr,
	output logic [graph_fetch_pkg::DATA_W-1:0] wb_dat_o,
	output logic                               wb_ack
);
	timeunit 1ns;
	timeprecision 1ps;
	import graph_fetch_pkg::*;

	int                seed;
	int                wait_left;
	logic              in_cycle;
	logic [ADDR_W-1:0] address_log [$];

	// Memory contents, a fixed mix of the whole byte address
	function automatic logic [DATA_W-1:0] vertex_word(input logic [ADDR_W-1:0] address);
		return (address * 32'h9E37_79B1) ^ {address[15:0], address[31:16]} ^ 32'h5A5A_0F0F;
	endfunction

	initial seed = SEED;

	////////////////////
	// Classic read slave
	////////////////////

	always @(posedge clock or negedge rstn) begin : respond
		int waits;
		if (!rstn) begin
			wb_ack    <= 1'b0;
			wb_dat_o  <= '0;
			in_cycle  <= 1'b0;
			wait_left <= 0;
		end else begin
			wb_ack <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack) begin
				// New cycle draws its wait states once
				if (in_cycle) begin
					waits = wait_left;
				end else begin
					waits = $unsigned($random(seed)) % (MAX_WAIT + 1);
				end
				if (waits == 0) begin
					wb_ack   <= 1'b1;
					wb_dat_o <= vertex_word(wb_adr);
					in_cycle <= 1'b0;
					address_log.push_back(wb_adr);
				end else begin
					wait_left <= waits - 1;
					in_cycle  <= 1'b1;
				end
			end
		end
	end

endmodule

// File: tests/tb_edge_data_fetch.sv
module tb_edge_data_fetch;
	timeunit 1ns;
	timeprecision 1ps;
	import graph_fetch_pkg::*;

	localparam int JOB_COUNT       = 200;
	localparam int STALL_JOBS      = 60;
	localparam int DISABLE_JOBS    = 8;
	localparam int TOTAL_JOBS      = 1 + JOB_COUNT + STALL_JOBS + DISABLE_JOBS;
	localparam int SEED            = 3;
	localparam int MAX_WAIT        = 3;
	localparam int WATCHDOG_CYCLES = TOTAL_JOBS * 40 + 2000;
	localparam logic [ADDR_W-1:0] BASE_ADDRESS = 32'h0010_0000;

	logic                   clock;
	logic                   rstn;
	logic                   enabled;
	logic [ADDR_W-1:0]      data_base;
	logic                   edge_job_valid;
	logic [VERTEX_ID_W-1:0] edge_job_src;
	logic [VERTEX_ID_W-1:0] edge_job_dest;
	logic                   edge_request;
	logic                   edge_data_request;
	logic                   edge_data_valid;
	logic [VERTEX_ID_W-1:0] edge_data_dest;
	logic [DATA_W-1:0]      edge_data_value;
	logic                   edge_data_empty;
	logic                   wb_cyc;
	logic                   wb_stb;
	logic [ADDR_W-1:0]      wb_adr;
	logic [DATA_W-1:0]      wb_dat_i;
	logic                   wb_ack;

	int seed;
	int output_errors;
	int control_errors;
	int issued_count;
	int received_count;
	int address_checked;
	bit consumer_on;
	bit ack_seen;

	// Expected results in job order
	logic [VERTEX_ID_W-1:0] expected_dest [$];
	logic [DATA_W-1:0]      expected_value [$];
	logic [ADDR_W-1:0]      expected_address [$];

	edge_data_fetch_top dut (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.data_base        (data_base),
		.edge_job_valid   (edge_job_valid),
		.edge_job_src     (edge_job_src),
		.edge_job_dest    (edge_job_dest),
		.edge_request     (edge_request),
		.edge_data_request(edge_data_request),
		.edge_data_valid  (edge_data_valid),
		.edge_data_dest   (edge_data_dest),
		.edge_data_value  (edge_data_value),
		.edge_data_empty  (edge_data_empty),
		.wb_cyc           (wb_cyc),
		.wb_stb           (wb_stb),
		.wb_adr           (wb_adr),
		.wb_dat_i         (wb_dat_i),
		.wb_ack           (wb_ack)
	);

	wb_vertex_memory_model #(
		.SEED    (SEED),
		.MAX_WAIT(MAX_WAIT)
	) memory (
		.clock   (clock),
		.rstn    (rstn),
		.wb_cyc  (wb_cyc),
		.wb_stb  (wb_stb),
		.wb_adr  (wb_adr),
		.wb_dat_o(wb_dat_i),
		.wb_ack  (wb_ack)
	);

	always #5 clock = ~clock;

	////////////////////
	// Reference model
	////////////////////

	// Four bytes per vertex from the array base
	function automatic logic [ADDR_W-1:0] vertex_address(input logic [ADDR_W-1:0] base,
		input logic [VERTEX_ID_W-1:0] dest);
		return base + ADDR_W'(dest) * 4;
	endfunction

	function automatic logic [DATA_W-1:0] reference_word(input logic [ADDR_W-1:0] base,
		input logic [VERTEX_ID_W-1:0] dest);
		logic [ADDR_W-1:0] address;
		address = vertex_address(base, dest);
		return (address * 32'h9E37_79B1) ^ {address[15:0], address[31:16]} ^ 32'h5A5A_0F0F;
	endfunction

	////////////////////
	// Stimulus tasks
	////////////////////

	task automatic check_level(input string name, input logic actual, input logic expected);
		assert (actual === expected) else begin
			control_errors++;
			$display("Mismatch at %0t: %s = %0b, expected %0b", $time, name, actual, expected);
		end
	endtask

	// Presents a job only after seeing edge_request high
	task automatic send_job(input logic [VERTEX_ID_W-1:0] dest);
		@(negedge clock);
		while (!edge_request) begin
			edge_job_valid = 1'b0;
			@(negedge clock);
		end
		edge_job_valid = 1'b1;
		edge_job_src   = VERTEX_ID_W'($random(seed));
		edge_job_dest  = dest;
		expected_dest.push_back(dest);
		expected_value.push_back(reference_word(data_base, dest));
		expected_address.push_back(vertex_address(data_base, dest));
		issued_count++;
	endtask

	task automatic send_random_jobs(input int count);
		for (int i = 0; i < count; i++) begin
			send_job(VERTEX_ID_W'($random(seed)));
		end
		@(negedge clock);
		edge_job_valid = 1'b0;
	endtask

	task automatic wait_for_drain(input int limit_cycles);
		int cycles;
		cycles = 0;
		while (received_count < issued_count && cycles < limit_cycles) begin
			@(negedge clock);
			cycles++;
		end
		assert (received_count == issued_count) else begin
			control_errors++;
			$display("Timed out at %0t waiting for edge data, %0d of %0d items received",
				$time, received_count, issued_count);
		end
	endtask

	// Consumer stalled until edge_request drops, then resumed
	task automatic run_stall_test;
		bit dropped;
		dropped     = 1'b0;
		consumer_on = 1'b0;
		fork
			send_random_jobs(STALL_JOBS);
			begin
				for (int i = 0; i < 400 && !dropped; i++) begin
					@(negedge clock);
					dropped = !edge_request;
				end
				assert (dropped) else begin
					control_errors++;
					$display("edge_request never dropped while the consumer was stalled");
				end
				repeat (20) @(negedge clock);
				consumer_on = 1'b1;
			end
		join
		wait_for_drain(STALL_JOBS * 40);
	endtask

	task automatic check_idle_while_disabled(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			check_level("wb_cyc", wb_cyc, 1'b0);
			check_level("wb_stb", wb_stb, 1'b0);
			check_level("edge_data_valid", edge_data_valid, 1'b0);
		end
	endtask

	////////////////////
	// Consumer and checker
	////////////////////

	initial begin
		edge_data_request = 1'b0;
		forever begin
			@(negedge clock);
			edge_data_request = consumer_on && rstn && !edge_data_empty;
		end
	end

	always @(negedge clock) begin : compare_outputs
		logic [VERTEX_ID_W-1:0] want_dest;
		logic [DATA_W-1:0]      want_value;
		if (rstn && edge_data_valid) begin
			assert (expected_dest.size() > 0) else begin
				output_errors++;
				$display("Edge data item at %0t with no job outstanding", $time);
			end
			if (expected_dest.size() > 0) begin
				want_dest  = expected_dest.pop_front();
				want_value = expected_value.pop_front();
				received_count++;
				assert (edge_data_dest == want_dest) else begin
					output_errors++;
					$display("Mismatch at %0t: edge_data_dest = 0x%0h, expected 0x%0h",
						$time, edge_data_dest, want_dest);
				end
				assert (edge_data_value == want_value) else begin
					output_errors++;
					$display("Mismatch at %0t: edge_data_value = 0x%0h, expected 0x%0h",
						$time, edge_data_value, want_value);
				end
			end
		end
		// Strobe spans the whole single read and both drop after the ack
		if (rstn) begin
			assert (wb_stb == wb_cyc) else begin
				output_errors++;
				$display("Mismatch at %0t: wb_stb = %0b, expected %0b", $time, wb_stb, wb_cyc);
			end
			assert (!ack_seen || !wb_cyc) else begin
				output_errors++;
				$display("Wishbone cycle still open at %0t in the cycle after its ack", $time);
			end
		end
		ack_seen = rstn && wb_ack;
		// Bus addresses in job order
		while (address_checked < memory.address_log.size()) begin
			assert (address_checked < expected_address.size()) else begin
				output_errors++;
				$display("Wishbone read at %0t with no job behind it", $time);
			end
			if (address_checked < expected_address.size()) begin
				assert (memory.address_log[address_checked] == expected_address[address_checked])
				else begin
					output_errors++;
					$display("Mismatch at %0t: wb_adr = 0x%0h, expected 0x%0h", $time,
						memory.address_log[address_checked], expected_address[address_checked]);
				end
			end
			address_checked++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles before the tests finished",
			WATCHDOG_CYCLES);
		$display("Errors: %0d in edge data and addresses, %0d in control checks",
			output_errors, control_errors);
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		clock          = 1'b0;
		rstn           = 1'b0;
		enabled        = 1'b0;
		data_base      = BASE_ADDRESS;
		edge_job_valid = 1'b0;
		edge_job_src   = '0;
		edge_job_dest  = '0;
		seed           = SEED;
		output_errors  = 0;
		control_errors = 0;
		issued_count   = 0;
		received_count = 0;
		address_checked = 0;
		consumer_on    = 1'b0;
		ack_seen       = 1'b0;
		repeat (10) @(posedge clock);
		@(negedge clock);

		// Reset state
		check_level("edge_request", edge_request, 1'b0);
		check_level("edge_data_valid", edge_data_valid, 1'b0);
		check_level("edge_data_empty", edge_data_empty, 1'b1);
		check_level("wb_cyc", wb_cyc, 1'b0);
		check_level("wb_stb", wb_stb, 1'b0);
		rstn = 1'b1;
		@(negedge clock);

		enabled     = 1'b1;
		consumer_on = 1'b1;
		send_job(16'h0123);
		@(negedge clock);
		edge_job_valid = 1'b0;
		wait_for_drain(100);

		send_random_jobs(JOB_COUNT);
		wait_for_drain(JOB_COUNT * 40);

		run_stall_test();

		// Jobs left pending across a disabled window
		send_random_jobs(DISABLE_JOBS);
		enabled = 1'b0;
		repeat (20) @(negedge clock);
		check_idle_while_disabled(60);
		enabled = 1'b1;
		wait_for_drain(DISABLE_JOBS * 40);

		repeat (20) @(negedge clock);
		assert (address_checked == issued_count && expected_dest.size() == 0) else begin
			control_errors++;
			$display("Run ended with %0d Wishbone reads and %0d items left for %0d jobs",
				address_checked, expected_dest.size(), issued_count);
		end
		$display("Errors: %0d in edge data and addresses, %0d in control checks",
			output_errors, control_errors);
		if (output_errors == 0 && control_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: compile.f
rtl/graph_fetch_pkg.sv
rtl/sync_fifo.sv
rtl/edge_data_read_command_control.sv
rtl/vertex_read_wb_master.sv
rtl/edge_data_fetch_top.sv
tests/wb_vertex_memory_model.sv
tests/tb_edge_data_fetch.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the edge data fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_edge_data_fetch -f compile.f -o sim_edge_data_fetch

output="$(./obj_dir/sim_edge_data_fetch 2>&1)" || true
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
	exit 0
else
	exit 1
fi
